// ==== rd_guard.f ====
+incdir+source
source/axi_rd_pkg.sv
source/guard_reg_pkg.sv
source/slot_picker.sv
source/read_guard.sv
source/guard_regs.sv
source/rd_guard_top.sv
test/tb_clock_gen.sv
test/tb_rd_guard.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the guard testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rd_guard -f rd_guard.f \
  && ./obj_dir/Vtb_rd_guard > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== test/tb_rd_guard.sv ====
// Testbench for the read-channel guard: random read traffic against a
// reference model, latency, timeout, unwanted response and clearing checks

module tb_rd_guard
  import axi_rd_pkg::*;
  import guard_reg_pkg::*;
();

  // One outstanding read as the model sees it
  typedef struct packed {
    id_t   id;
    len_t  len;
    cnt_t  accum;
    cnt_t  edges;
    logic  matched;
  } model_rec_t;

  logic        clk;
  logic        rst_n;
  axi_rd_req_t mst_req;
  axi_rd_rsp_t slv_rsp;
  logic        reset_clear;
  logic        reg_we;
  reg_addr_t   reg_addr;
  reg_data_t   reg_wdata;
  reg_data_t   reg_rdata;
  logic        irq;
  logic        reset_req;

  model_rec_t model_q[$];
  cnt_t       budget_val;
  logic       watch_irq;
  logic       lat_pending;
  cnt_t       lat_exp;

  tb_clock_gen i_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  rd_guard_top i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .mst_req_i    (mst_req),
    .slv_rsp_i    (slv_rsp),
    .reset_clear_i(reset_clear),
    .reg_we_i     (reg_we),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .irq_o        (irq),
    .reset_req_o  (reset_req)
  );

  // Loaded budget, less the counting edges seen since enqueue
  function automatic cnt_t ref_latency(input cnt_t budget, input cnt_t accum,
                                       input len_t len, input cnt_t edges);
    cnt_t loaded;
    loaded = cnt_t'(budget * (accum + cnt_t'(len)));
    return loaded - edges;
  endfunction

  function automatic ar_chan_t random_ar();
    ar_chan_t ar;
    ar.id   = id_t'($urandom_range(0, 5));
    ar.addr = addr_t'($urandom());
    ar.len  = len_t'($urandom_range(1, 8));
    return ar;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_status(input string name, input irq_status_t got, input irq_status_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic drive_idle();
    mst_req.ar_valid = 1'b0;
    slv_rsp.ar_ready = 1'b0;
    slv_rsp.r_valid  = 1'b0;
    slv_rsp.r.last   = 1'b0;
    reg_we           = 1'b0;
    reset_clear      = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    @(negedge clk);
    drive_idle();
    reg_addr = addr;
    #1;
    data = reg_rdata;
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk);
    drive_idle();
    reg_addr  = addr;
    reg_wdata = data;
    reg_we    = 1'b1;
    @(posedge clk);
  endtask

  // Applies one rising edge to the model
  task automatic update_model(input logic did_ar, input ar_chan_t ar,
                              input logic did_r, input id_t r_id);
    cnt_t       accum;
    model_rec_t rec;
    int         hit;
    accum = '0;
    hit   = -1;
    foreach (model_q[i]) begin
      accum += cnt_t'(model_q[i].len);
      if (model_q[i].matched) begin
        hit = i;
      end
    end
    // Record matched on the previous edge retires now
    if (hit >= 0) begin
      lat_exp = ref_latency(budget_val, model_q[hit].accum, model_q[hit].len,
                            model_q[hit].edges);
      lat_pending = 1'b1;
      model_q.delete(hit);
    end
    // Counters hold on an R last edge
    if (!did_r) begin
      foreach (model_q[i]) begin
        if (!model_q[i].matched) begin
          model_q[i].edges++;
        end
      end
    end
    if (did_r) begin
      hit = -1;
      foreach (model_q[i]) begin
        if (hit < 0 && !model_q[i].matched && model_q[i].id == r_id) begin
          hit = i;
        end
      end
      if (hit < 0) begin
        fail_run("testbench sent a response for an ID with no outstanding read");
      end else begin
        model_q[hit].matched = 1'b1;
      end
    end
    if (did_ar) begin
      rec = '{id: ar.id, len: ar.len, accum: accum, edges: '0, matched: 1'b0};
      model_q.push_back(rec);
    end
  endtask

  task automatic step(input logic do_ar, input ar_chan_t ar, input logic do_r, input id_t r_id);
    @(negedge clk);
    drive_idle();
    mst_req.ar       = ar;
    mst_req.ar_valid = do_ar;
    slv_rsp.ar_ready = do_ar;
    slv_rsp.r.id     = r_id;
    slv_rsp.r.data   = data_t'($urandom());
    slv_rsp.r_valid  = do_r;
    slv_rsp.r.last   = do_r;
    @(posedge clk);
    update_model(do_ar, ar, do_r, r_id);
  endtask

  task automatic run_traffic(input int unsigned n_txn);
    int unsigned issued;
    int unsigned guard_cnt;
    int          pick;
    logic        do_ar;
    logic        do_r;
    ar_chan_t    ar;
    id_t         r_id;
    issued    = 0;
    guard_cnt = 0;
    @(negedge clk);
    drive_idle();
    reg_addr  = reg_addr_t'(4);
    watch_irq = 1'b1;
    while (issued < n_txn || model_q.size() > 0) begin
      guard_cnt++;
      if (guard_cnt > 5000) begin
        fail_run("read traffic did not drain in time");
      end
      ar    = random_ar();
      do_ar = (issued < n_txn) && (model_q.size() < 4) && ($urandom_range(0, 1) == 1);
      pick  = -1;
      foreach (model_q[i]) begin
        if (pick < 0 && !model_q[i].matched) begin
          pick = i;
        end
      end
      // Oldest read is forced out once it has waited long
      if (pick >= 0 && model_q[pick].edges < 10) begin
        if ($urandom_range(0, 2) == 0) begin
          pick = $urandom_range(0, model_q.size() - 1);
          if (model_q[pick].matched) begin
            pick = -1;
          end
        end else begin
          pick = -1;
        end
      end
      do_r = (pick >= 0);
      r_id = do_r ? model_q[pick].id : '0;
      step(do_ar, ar, do_r, r_id);
      if (do_ar) begin
        issued++;
      end
    end
    repeat (2) step(1'b0, ar, 1'b0, '0);
    watch_irq = 1'b0;
  endtask

  task automatic clear_fault();
    reg_data_t   rd;
    irq_status_u st;
    @(negedge clk);
    drive_idle();
    reset_clear = 1'b1;
    @(negedge clk);
    drive_idle();
    #1;
    check_flag("reset_req_o", reset_req, 1'b0);
    write_reg(reg_addr_t'(1), reg_data_t'($urandom()));
    read_reg(reg_addr_t'(1), rd);
    st.raw = rd;
    check_status("irq_status", st.fields, '0);
    read_reg(reg_addr_t'(3), rd);
    check_flag("reset", rd[0], 1'b0);
  endtask

  // Per-cycle checks of interrupt, reset request and latency
  initial begin : compare_proc
    forever begin
      @(negedge clk);
      #1;
      if (watch_irq) begin
        check_flag("irq_o", irq, 1'b0);
        check_flag("reset_req_o", reset_req, 1'b0);
      end
      if (lat_pending) begin
        lat_pending = 1'b0;
        check_count("latency_read", cnt_t'(reg_rdata), lat_exp);
      end
    end
  end

  initial begin : stimulus
    int unsigned wait_cnt;
    reg_data_t   rd;
    irq_status_u st;
    irq_status_t exp_st;
    ar_chan_t    ar;
    cnt_t        edges;
    cnt_t        exp_edges;
    id_t         bad_id;
    logic        seen;
    mst_req     = '0;
    slv_rsp     = '0;
    reset_clear = 1'b0;
    reg_we      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    watch_irq   = 1'b0;
    lat_pending = 1'b0;
    lat_exp     = '0;
    budget_val  = '0;
    void'($urandom(32'h10ca_d4bc));
    mst_req.r_ready = 1'b1;

    wait_cnt = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > 20) begin
        fail_run("reset was never released");
      end
    end

    // Everything idle and zero out of reset
    @(negedge clk);
    drive_idle();
    #1;
    check_flag("irq_o", irq, 1'b0);
    check_flag("reset_req_o", reset_req, 1'b0);
    read_reg(reg_addr_t'(0), rd);
    check_count("budget_read", cnt_t'(rd), '0);
    read_reg(reg_addr_t'(1), rd);
    st.raw = rd;
    check_status("irq_status", st.fields, '0);
    read_reg(reg_addr_t'(2), rd);
    check_addr("irq_addr", addr_t'(rd), '0);
    read_reg(reg_addr_t'(3), rd);
    check_flag("reset", rd[0], 1'b0);
    read_reg(reg_addr_t'(4), rd);
    check_count("latency_read", cnt_t'(rd), '0);

    // Well-behaved traffic
    write_reg(reg_addr_t'(0), reg_data_t'(40));
    budget_val = cnt_t'(40);
    read_reg(reg_addr_t'(0), rd);
    check_count("budget_read", cnt_t'(rd), budget_val);
    run_traffic(40);
    read_reg(reg_addr_t'(1), rd);
    st.raw = rd;
    check_status("irq_status", st.fields, '0);

    // One read left unanswered
    write_reg(reg_addr_t'(0), reg_data_t'(4));
    budget_val = cnt_t'(4);
    ar = random_ar();
    step(1'b1, ar, 1'b0, '0);
    exp_edges = ref_latency(budget_val, '0, ar.len, '0);
    edges     = '0;
    seen      = 1'b0;
    while (!seen) begin
      @(negedge clk);
      drive_idle();
      #1;
      if (irq) begin
        seen = 1'b1;
      end else if (edges > exp_edges + 4) begin
        fail_run("timeout interrupt did not arrive");
      end else begin
        check_flag("reset_req_o", reset_req, 1'b0);
        @(posedge clk);
        edges++;
      end
    end
    check_count("edges to timeout", edges, exp_edges);
    check_flag("reset_req_o", reset_req, 1'b0);
    model_q.delete();
    @(negedge clk);
    drive_idle();
    #1;
    check_flag("reset_req_o", reset_req, 1'b1);
    check_flag("irq_o", irq, 1'b0);
    read_reg(reg_addr_t'(1), rd);
    st.raw = rd;
    exp_st            = '0;
    exp_st.rd_timeout = 1'b1;
    exp_st.irq        = 1'b1;
    exp_st.txn_id     = ar.id;
    check_status("irq_status", st.fields, exp_st);
    read_reg(reg_addr_t'(2), rd);
    check_addr("irq_addr", addr_t'(rd), ar.addr);
    read_reg(reg_addr_t'(3), rd);
    check_flag("reset", rd[0], 1'b1);
    clear_fault();

    // R last beat for an ID with nothing outstanding
    bad_id = id_t'($urandom_range(0, 15));
    @(negedge clk);
    drive_idle();
    slv_rsp.r.id    = bad_id;
    slv_rsp.r_valid = 1'b1;
    slv_rsp.r.last  = 1'b1;
    #1;
    check_flag("irq_o", irq, 1'b1);
    @(negedge clk);
    drive_idle();
    #1;
    check_flag("reset_req_o", reset_req, 1'b1);
    check_flag("irq_o", irq, 1'b0);
    read_reg(reg_addr_t'(1), rd);
    st.raw = rd;
    exp_st                  = '0;
    exp_st.unwanted_rd_resp = 1'b1;
    exp_st.irq              = 1'b1;
    check_status("irq_status", st.fields, exp_st);
    read_reg(reg_addr_t'(2), rd);
    check_addr("irq_addr", addr_t'(rd), ar.addr);
    clear_fault();

    // Tracking works again after clearing
    write_reg(reg_addr_t'(0), reg_data_t'(40));
    budget_val = cnt_t'(40);
    run_traffic(20);
    read_reg(reg_addr_t'(1), rd);
    st.raw = rd;
    check_status("irq_status", st.fields, '0);
    read_reg(reg_addr_t'(3), rd);
    check_flag("reset", rd[0], 1'b0);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== test/tb_clock_gen.sv ====
// Testbench clock and power-on reset

module tb_clock_gen #(
  parameter int unsigned HalfPeriod  = 2,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Reset released away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== source/rd_guard_top.sv ====
// Read-channel guard top: guard core and its register block

module rd_guard_top
  import axi_rd_pkg::*;
  import guard_reg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  axi_rd_req_t mst_req_i,
  input  axi_rd_rsp_t slv_rsp_i,
  input  logic        reset_clear_i,
  input  logic        reg_we_i,
  input  reg_addr_t   reg_addr_i,
  input  reg_data_t   reg_wdata_i,
  output reg_data_t   reg_rdata_o,
  output logic        irq_o,
  output logic        reset_req_o
);

  reg2hw_t reg2hw;
  hw2reg_t hw2reg;

  read_guard i_read_guard (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mst_req_i    (mst_req_i),
    .slv_rsp_i    (slv_rsp_i),
    .reset_clear_i(reset_clear_i),
    .reg2hw_i     (reg2hw),
    .hw2reg_o     (hw2reg),
    .irq_o        (irq_o),
    .reset_req_o  (reset_req_o)
  );

  guard_regs i_guard_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .reg_we_i   (reg_we_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o),
    .hw2reg_i   (hw2reg),
    .reg2hw_o   (reg2hw)
  );

endmodule

// ==== source/guard_regs.sv ====
// Guard register file: budget, IRQ status, offending address,
// latched reset and last read latency, behind a strobe register port

module guard_regs
  import guard_reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      reg_we_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  input  hw2reg_t   hw2reg_i,
  output reg2hw_t   reg2hw_o
);

  localparam reg_addr_t AddrBudget  = reg_addr_t'(0);
  localparam reg_addr_t AddrStatus  = reg_addr_t'(1);
  localparam reg_addr_t AddrIrqAddr = reg_addr_t'(2);
  localparam reg_addr_t AddrReset   = reg_addr_t'(3);
  localparam reg_addr_t AddrLatency = reg_addr_t'(4);

  cnt_t                      budget_q, latency_q;
  irq_status_u               status_q;
  logic [`RG_ADDR_WIDTH-1:0] irq_addr_q;
  logic                      reset_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      budget_q   <= '0;
      status_q   <= '0;
      irq_addr_q <= '0;
      reset_q    <= 1'b0;
      latency_q  <= '0;
    end else begin
      if (reg_we_i && reg_addr_i == AddrBudget) begin
        budget_q <= cnt_t'(reg_wdata_i);
      end
      // Hardware update wins over a clearing write
      if (hw2reg_i.irq_status.de) begin
        status_q <= hw2reg_i.irq_status.d;
      end else if (reg_we_i && reg_addr_i == AddrStatus) begin
        status_q <= '0;
      end
      if (hw2reg_i.irq_addr.de) begin
        irq_addr_q <= hw2reg_i.irq_addr.d;
      end
      if (hw2reg_i.reset.de) begin
        reset_q <= hw2reg_i.reset.d;
      end
      if (hw2reg_i.latency_read.de) begin
        latency_q <= hw2reg_i.latency_read.d;
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      AddrBudget:  reg_rdata_o = reg_data_t'(budget_q);
      AddrStatus:  reg_rdata_o = status_q.raw;
      AddrIrqAddr: reg_rdata_o = reg_data_t'(irq_addr_q);
      AddrReset:   reg_rdata_o = reg_data_t'(reset_q);
      AddrLatency: reg_rdata_o = reg_data_t'(latency_q);
      default:     reg_rdata_o = '0;
    endcase
  end

  assign reg2hw_o.budget_read = budget_q;
  assign reg2hw_o.irq_status  = status_q;
  assign reg2hw_o.irq_addr    = irq_addr_q;

  a_mapped_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_we_i |-> reg_addr_i <= AddrLatency);

endmodule

// ==== source/read_guard.sv ====
// Read transaction tracker: per-ID linked lists of outstanding ARs,
// budget counters, timeout and unwanted-response detection

`include "rd_guard_settings.svh"

module read_guard
  import axi_rd_pkg::*;
  import guard_reg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  axi_rd_req_t mst_req_i,
  input  axi_rd_rsp_t slv_rsp_i,
  input  logic        reset_clear_i,
  input  reg2hw_t     reg2hw_i,
  output hw2reg_t     hw2reg_o,
  output logic        irq_o,
  output logic        reset_req_o
);

  localparam int unsigned MaxRdTxns  = `RG_MAX_RD_TXNS;
  localparam int unsigned HtCapacity = (`RG_MAX_UNIQ_IDS <= `RG_MAX_RD_TXNS) ?
                                       `RG_MAX_UNIQ_IDS : `RG_MAX_RD_TXNS;
  localparam int unsigned HtIdxWidth = (HtCapacity > 1) ? $clog2(HtCapacity) : 1;
  localparam int unsigned LdIdxWidth = (MaxRdTxns > 1) ? $clog2(MaxRdTxns) : 1;

  typedef logic [HtIdxWidth-1:0] ht_idx_t;
  typedef logic [LdIdxWidth-1:0] ld_idx_t;

  // One list per ID, head is the oldest record
  typedef struct packed {
    id_t     id;
    ld_idx_t head;
    ld_idx_t tail;
    logic    free;
  } head_tail_t;

  typedef struct packed {
    ar_chan_t meta;
    cnt_t     counter;
    logic     found_match;
    ld_idx_t  next;
    logic     free;
  } linked_data_t;

  localparam head_tail_t   HtEmpty = '{free: 1'b1, default: '0};
  localparam linked_data_t LdEmpty = '{free: 1'b1, default: '0};

  head_tail_t   [HtCapacity-1:0] ht_d, ht_q;
  linked_data_t [MaxRdTxns-1:0]  ld_d, ld_q;

  logic [HtCapacity-1:0] ht_free;
  logic [MaxRdTxns-1:0]  ld_free;
  ht_idx_t ht_free_idx, in_idx, rsp_idx, pop_ht, new_ht;
  ld_idx_t ld_free_idx, pop_ld, rsp_head, rsp_target, new_ld;
  logic    ht_none, ld_none, ar_hs, r_last_hs;
  logic    in_hit, rsp_hit, rsp_busy, rsp_tracked, pop, pop_last;
  logic    timeout, unwanted, reset_req_d, reset_req_q, dup_id;
  ld_idx_t to_slot;
  cnt_t    accum_len, txn_budget;
  irq_status_u status_d;

  assign ar_hs     = mst_req_i.ar_valid && slv_rsp_i.ar_ready;
  assign r_last_hs = slv_rsp_i.r_valid && mst_req_i.r_ready && slv_rsp_i.r.last;

  for (genvar i = 0; i < HtCapacity; i++) begin : gen_ht_free
    assign ht_free[i] = ht_q[i].free;
  end
  for (genvar i = 0; i < MaxRdTxns; i++) begin : gen_ld_free
    assign ld_free[i] = ld_q[i].free;
  end

  slot_picker #(.Width(HtCapacity)) i_ht_picker (
    .flags_i(ht_free),
    .idx_o  (ht_free_idx),
    .none_o (ht_none)
  );

  slot_picker #(.Width(MaxRdTxns)) i_ld_picker (
    .flags_i(ld_free),
    .idx_o  (ld_free_idx),
    .none_o (ld_none)
  );

  // ID lookups for the incoming AR and the R beat
  always_comb begin : proc_lookup
    in_hit  = 1'b0;
    in_idx  = '0;
    rsp_hit = 1'b0;
    rsp_idx = '0;
    for (int i = 0; i < HtCapacity; i++) begin
      if (!ht_q[i].free && ht_q[i].id == mst_req_i.ar.id) begin
        in_hit = 1'b1;
        in_idx = ht_idx_t'(i);
      end
      if (!ht_q[i].free && ht_q[i].id == slv_rsp_i.r.id) begin
        rsp_hit = 1'b1;
        rsp_idx = ht_idx_t'(i);
      end
    end
    // Head may already be matched and waiting to retire
    rsp_head    = ht_q[rsp_idx].head;
    rsp_busy    = ld_q[rsp_head].found_match;
    rsp_tracked = rsp_hit && !(rsp_busy && rsp_head == ht_q[rsp_idx].tail);
    rsp_target  = rsp_busy ? ld_q[rsp_head].next : rsp_head;
  end

  // Matched record and the list that owns it
  always_comb begin : proc_retire
    pop    = 1'b0;
    pop_ld = '0;
    pop_ht = '0;
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (!ld_q[i].free && ld_q[i].found_match) begin
        pop    = 1'b1;
        pop_ld = ld_idx_t'(i);
      end
    end
    for (int j = 0; j < HtCapacity; j++) begin
      if (!ht_q[j].free && ht_q[j].head == pop_ld) begin
        pop_ht = ht_idx_t'(j);
      end
    end
    pop_last = (ht_q[pop_ht].tail == pop_ld);
  end

  always_comb begin : proc_budget
    accum_len = '0;
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (!ld_q[i].free) begin
        accum_len += cnt_t'(ld_q[i].meta.len);
      end
    end
  end

  assign txn_budget = reg2hw_i.budget_read * (accum_len + cnt_t'(mst_req_i.ar.len));

  always_comb begin : proc_fault
    timeout = 1'b0;
    to_slot = '0;
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (!ld_q[i].free && !ld_q[i].found_match && ld_q[i].counter == '0) begin
        timeout = 1'b1;
        to_slot = ld_idx_t'(i);
      end
    end
    unwanted = r_last_hs && !rsp_tracked;
  end

  assign irq_o       = timeout || unwanted;
  assign reset_req_d = irq_o || (reset_req_q && !reset_clear_i);
  assign reset_req_o = reset_req_q;

  always_comb begin : proc_tables
    ht_d   = ht_q;
    ld_d   = ld_q;
    new_ld = ld_none ? pop_ld : ld_free_idx;
    new_ht = '0;
    // Budgets run except on an R last handshake
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (!ld_q[i].free && !r_last_hs) begin
        ld_d[i].counter = ld_q[i].counter - 1'b1;
      end
    end
    if (r_last_hs && rsp_tracked) begin
      ld_d[rsp_target].found_match = 1'b1;
    end
    if (pop) begin
      ld_d[pop_ld] = LdEmpty;
      if (pop_last) begin
        ht_d[pop_ht] = HtEmpty;
      end else begin
        ht_d[pop_ht].head = ld_q[pop_ld].next;
      end
    end
    if (ar_hs) begin
      if (in_hit && !(pop && pop_last && pop_ht == in_idx)) begin
        ld_d[ht_q[in_idx].tail].next = new_ld;
        ht_d[in_idx].tail            = new_ld;
      end else begin
        // Reopen the same entry, else take a free one or the one just emptied
        if (in_hit) begin
          new_ht = in_idx;
        end else if (ht_none) begin
          new_ht = pop_ht;
        end else begin
          new_ht = ht_free_idx;
        end
        ht_d[new_ht] = '{id: mst_req_i.ar.id, head: new_ld, tail: new_ld, free: 1'b0};
      end
      ld_d[new_ld] = '{meta: mst_req_i.ar, counter: txn_budget, found_match: 1'b0,
                       next: '0, free: 1'b0};
    end
    // Any fault drops every record
    if (irq_o) begin
      for (int i = 0; i < MaxRdTxns; i++) begin
        ld_d[i] = LdEmpty;
      end
      for (int j = 0; j < HtCapacity; j++) begin
        ht_d[j] = HtEmpty;
      end
    end
  end

  always_comb begin : proc_hw2reg
    status_d = reg2hw_i.irq_status;
    if (timeout) begin
      status_d.fields.rd_timeout = 1'b1;
      status_d.fields.irq        = 1'b1;
      status_d.fields.txn_id     = ld_q[to_slot].meta.id;
    end
    if (unwanted) begin
      status_d.fields.unwanted_rd_resp = 1'b1;
      status_d.fields.irq              = 1'b1;
    end
    hw2reg_o.irq_status.d   = status_d;
    hw2reg_o.irq_status.de  = irq_o;
    hw2reg_o.irq_addr.d     = timeout ? ld_q[to_slot].meta.addr : reg2hw_i.irq_addr;
    hw2reg_o.irq_addr.de    = timeout;
    hw2reg_o.reset.d        = reset_req_d;
    hw2reg_o.reset.de       = reset_req_d != reset_req_q;
    hw2reg_o.latency_read.d = ld_q[pop_ld].counter;
    hw2reg_o.latency_read.de = pop;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int j = 0; j < HtCapacity; j++) begin
        ht_q[j] <= HtEmpty;
      end
      for (int i = 0; i < MaxRdTxns; i++) begin
        ld_q[i] <= LdEmpty;
      end
      reset_req_q <= 1'b0;
    end else begin
      ht_q        <= ht_d;
      ld_q        <= ld_d;
      reset_req_q <= reset_req_d;
    end
  end

  always_comb begin : proc_dup_check
    dup_id = 1'b0;
    for (int i = 0; i < HtCapacity; i++) begin
      for (int j = i + 1; j < HtCapacity; j++) begin
        if (!ht_q[i].free && !ht_q[j].free && ht_q[i].id == ht_q[j].id) begin
          dup_id = 1'b1;
        end
      end
    end
  end

  a_unique_id: assert property (@(posedge clk_i) disable iff (!rst_ni) !dup_id);

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(reset_req_o) |-> $past(reset_clear_i));

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_hs |-> (!ld_none || pop));

endmodule

// ==== source/slot_picker.sv ====
// Lowest-set-bit finder for free-slot selection

module slot_picker #(
  parameter int unsigned Width = 4,
  localparam int unsigned IdxWidth = (Width > 1) ? $clog2(Width) : 1
) (
  input  logic [Width-1:0]    flags_i,
  output logic [IdxWidth-1:0] idx_o,
  output logic                none_o
);

  // Scan from the top so the lowest set bit wins
  always_comb begin
    idx_o  = '0;
    none_o = 1'b1;
    for (int i = Width - 1; i >= 0; i--) begin
      if (flags_i[i]) begin
        idx_o  = IdxWidth'(i);
        none_o = 1'b0;
      end
    end
    a_idx_set: assert (none_o || flags_i[idx_o])
      else $error("slot_picker points at a clear flag");
  end

endmodule

// ==== source/guard_reg_pkg.sv ====
// Register-facing types: IRQ status word and its union view,
// register-to-guard and guard-to-register bundles

`include "rd_guard_settings.svh"

package guard_reg_pkg;

  typedef logic [`RG_CNT_WIDTH-1:0]      cnt_t;
  typedef logic [`RG_REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`RG_REG_DATA_WIDTH-1:0] reg_data_t;

  // Status fields, padded to one register word
  typedef struct packed {
    logic [`RG_REG_DATA_WIDTH-`RG_ID_WIDTH-4:0] rsvd;
    logic                                       unwanted_rd_resp;
    logic                                       rd_timeout;
    logic                                       irq;
    logic [`RG_ID_WIDTH-1:0]                    txn_id;
  } irq_status_t;

  typedef union packed {
    irq_status_t fields;
    reg_data_t   raw;
  } irq_status_u;

  typedef struct packed {
    cnt_t                     budget_read;
    irq_status_u              irq_status;
    logic [`RG_ADDR_WIDTH-1:0] irq_addr;
  } reg2hw_t;

  // Hardware updates, each with its write enable
  typedef struct packed {
    struct packed {irq_status_u d; logic de;}               irq_status;
    struct packed {logic [`RG_ADDR_WIDTH-1:0] d; logic de;} irq_addr;
    struct packed {logic d; logic de;}                      reset;
    struct packed {cnt_t d; logic de;}                      latency_read;
  } hw2reg_t;

endpackage

// ==== source/axi_rd_pkg.sv ====
// AXI read channel types: AR and R beats,
// plus the observed request and response bundles

`include "rd_guard_settings.svh"

package axi_rd_pkg;

  typedef logic [`RG_ID_WIDTH-1:0]   id_t;
  typedef logic [`RG_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`RG_LEN_WIDTH-1:0]  len_t;
  typedef logic [`RG_DATA_WIDTH-1:0] data_t;

  // Read address beat
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  // Read data beat
  typedef struct packed {
    id_t   id;
    logic  last;
    data_t data;
  } r_chan_t;

  // Manager side, as seen on the bus
  typedef struct packed {
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_rd_req_t;

  // Subordinate side, as seen on the bus
  typedef struct packed {
    r_chan_t r;
    logic    r_valid;
    logic    ar_ready;
  } axi_rd_rsp_t;

endpackage

// ==== source/rd_guard_settings.svh ====
// Table sizes and field widths of the read-channel guard
// Shared by both packages and the guard core

`ifndef RD_GUARD_SETTINGS_SVH
`define RD_GUARD_SETTINGS_SVH

// Table capacities
`define RG_MAX_UNIQ_IDS 4
`define RG_MAX_RD_TXNS 4

// Budget counter
`define RG_CNT_WIDTH 16

// AXI read fields
`define RG_ID_WIDTH 4
`define RG_ADDR_WIDTH 32
`define RG_LEN_WIDTH 8
`define RG_DATA_WIDTH 32

// Register port
`define RG_REG_ADDR_WIDTH 4
`define RG_REG_DATA_WIDTH 32

`endif
